// File: src/core_pkg.sv
package core_pkg;

  localparam int xlen      = 32;
  localparam int reg_count = 32;
  localparam int hits_w    = 3;   // up to four operands per cycle

  typedef logic [4:0]        reg_addr_t;
  typedef logic [xlen-1:0]   xdata_t;
  typedef logic [31:0]       fwd_cnt_t;
  typedef logic [hits_w-1:0] fwd_hits_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt
  } alu_op_t;

endpackage

// File: src/dbg_map_pkg.sv
package dbg_map_pkg;

  localparam int axi_addr_w = 8;
  localparam int axi_data_w = 32;

  typedef logic [axi_addr_w-1:0] axi_addr_t;
  typedef logic [axi_data_w-1:0] axi_data_t;
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t resp_okay = 2'b00;

  localparam axi_addr_t dbg_reg_base = 8'h00;  // x0..x31, one word each
  localparam axi_addr_t dbg_fwd_cnt  = 8'h80;  // read count, write clears

  typedef enum logic [1:0] {
    dbg_idle,
    dbg_rd_rf,
    dbg_resp
  } dbg_rd_state_t;

endpackage

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      we0,
  input  reg_addr_t waddr0,
  input  xdata_t    wdata0,
  input  logic      we1,
  input  reg_addr_t waddr1,
  input  xdata_t    wdata1,
  input  reg_addr_t raddr0a,
  input  reg_addr_t raddr0b,
  input  reg_addr_t raddr1a,
  input  reg_addr_t raddr1b,
  input  reg_addr_t dbg_raddr,
  output xdata_t    rdata0a,
  output xdata_t    rdata0b,
  output xdata_t    rdata1a,
  output xdata_t    rdata1b,
  output xdata_t    dbg_rdata
);

  xdata_t regs [reg_count];

  function automatic xdata_t rd(input reg_addr_t a);
    return (a == '0) ? '0 : regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && waddr0 != '0) regs[waddr0] <= wdata0;
      if (we1 && waddr1 != '0) regs[waddr1] <= wdata1;  // lane 1 lands last
    end
  end

  assign rdata0a   = rd(raddr0a);
  assign rdata0b   = rd(raddr0b);
  assign rdata1a   = rd(raddr1a);
  assign rdata1b   = rd(raddr1b);
  assign dbg_rdata = rd(dbg_raddr);

endmodule

// File: src/forwarding.sv
`timescale 1ns/10ps

module forwarding
  import core_pkg::*;
(
  input  logic      rden1_0,
  input  logic      rden2_0,
  input  reg_addr_t raddr1_0,
  input  reg_addr_t raddr2_0,
  input  xdata_t    rdata1_0,
  input  xdata_t    rdata2_0,
  input  logic      rden1_1,
  input  logic      rden2_1,
  input  reg_addr_t raddr1_1,
  input  reg_addr_t raddr2_1,
  input  xdata_t    rdata1_1,
  input  xdata_t    rdata2_1,
  input  logic      mem_wren_0,
  input  reg_addr_t mem_waddr_0,
  input  xdata_t    mem_wdata_0,
  input  logic      wb_wren_0,
  input  reg_addr_t wb_waddr_0,
  input  xdata_t    wb_wdata_0,
  input  logic      mem_wren_1,
  input  reg_addr_t mem_waddr_1,
  input  xdata_t    mem_wdata_1,
  input  logic      wb_wren_1,
  input  reg_addr_t wb_waddr_1,
  input  xdata_t    wb_wdata_1,
  output xdata_t    data1_0,
  output xdata_t    data2_0,
  output xdata_t    data1_1,
  output xdata_t    data2_1,
  output fwd_hits_t fwd_hits
);

  logic [3:0] hit;

  // returns {forwarded, value}; newest stage first, lane 1 ahead of lane 0
  function automatic logic [xlen:0] pick(input logic rden, input reg_addr_t raddr,
                                         input xdata_t rdata);
    logic [xlen:0] res;
    res = '0;
    if (rden) begin
      if (mem_wren_1 && raddr == mem_waddr_1)     res = {1'b1, mem_wdata_1};
      else if (mem_wren_0 && raddr == mem_waddr_0) res = {1'b1, mem_wdata_0};
      else if (wb_wren_1 && raddr == wb_waddr_1)   res = {1'b1, wb_wdata_1};
      else if (wb_wren_0 && raddr == wb_waddr_0)   res = {1'b1, wb_wdata_0};
      else                                         res = {1'b0, rdata};
    end
    return res;
  endfunction

  assign {hit[0], data1_0} = pick(rden1_0, raddr1_0, rdata1_0);
  assign {hit[1], data2_0} = pick(rden2_0, raddr2_0, rdata2_0);
  assign {hit[2], data1_1} = pick(rden1_1, raddr1_1, rdata1_1);
  assign {hit[3], data2_1} = pick(rden2_1, raddr2_1, rdata2_1);

  always_comb begin
    fwd_hits = '0;
    for (int i = 0; i < 4; i++) begin
      fwd_hits = fwd_hits + fwd_hits_t'(hit[i]);
    end
  end

endmodule

// File: src/exec_lane.sv
`timescale 1ns/10ps

module exec_lane
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid,
  input  alu_op_t   op,
  input  reg_addr_t rd,
  input  logic      use_imm,
  input  xdata_t    imm,
  input  xdata_t    src1,
  input  xdata_t    src2,
  output logic      mem_wren,
  output reg_addr_t mem_waddr,
  output xdata_t    mem_wdata,
  output logic      wb_wren,
  output reg_addr_t wb_waddr,
  output xdata_t    wb_wdata
);

  xdata_t     opb;
  xdata_t     result;
  logic [4:0] shamt;

  assign opb   = use_imm ? imm : src2;
  assign shamt = opb[4:0];

  always_comb begin
    case (op)
      alu_add: result = src1 + opb;
      alu_sub: result = src1 - opb;
      alu_and: result = src1 & opb;
      alu_or:  result = src1 | opb;
      alu_xor: result = src1 ^ opb;
      alu_sll: result = src1 << shamt;
      alu_srl: result = src1 >> shamt;
      alu_slt: result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(opb)};
      default: result = '0;
    endcase
  end

  // enables carry reset, payload does not
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wren <= 1'b0;
      wb_wren  <= 1'b0;
    end else begin
      mem_wren <= valid && rd != '0;
      wb_wren  <= mem_wren;
    end
  end

  always_ff @(posedge clk) begin
    mem_waddr <= rd;
    mem_wdata <= result;
    wb_waddr  <= mem_waddr;
    wb_wdata  <= mem_wdata;
  end

endmodule

// File: src/dbg_regs.sv
`timescale 1ns/10ps

module dbg_regs
  import core_pkg::*, dbg_map_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  fwd_hits_t fwd_hits,
  output reg_addr_t dbg_raddr,
  input  xdata_t    dbg_rdata,
  input  axi_addr_t awaddr,
  input  logic      awvalid,
  output logic      awready,
  input  axi_data_t wdata,
  input  logic      wvalid,
  output logic      wready,
  output axi_resp_t bresp,
  output logic      bvalid,
  input  logic      bready,
  input  axi_addr_t araddr,
  input  logic      arvalid,
  output logic      arready,
  output axi_data_t rdata,
  output axi_resp_t rresp,
  output logic      rvalid,
  input  logic      rready
);

  fwd_cnt_t      fwd_cnt;
  dbg_rd_state_t rd_state;
  axi_addr_t     ar_addr;
  axi_addr_t     reg_off;
  axi_data_t     rd_word;
  logic          wr_take;

  // write channel, ready pulses once both address and data wait
  assign wr_take = awready & awvalid & wvalid;
  assign wready  = awready;
  assign bresp   = resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      if (wr_take)     bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
    end
  end

  // wrapping count, clear wins over this cycle's hits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fwd_cnt <= '0;
    end else if (wr_take && awaddr == dbg_fwd_cnt) begin
      fwd_cnt <= '0;
    end else begin
      fwd_cnt <= fwd_cnt + fwd_cnt_t'(fwd_hits);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= dbg_idle;
    end else begin
      case (rd_state)
        dbg_idle:  if (arvalid) rd_state <= dbg_rd_rf;
        dbg_rd_rf: rd_state <= dbg_resp;
        dbg_resp:  if (rready) rd_state <= dbg_idle;
        default:   rd_state <= dbg_idle;
      endcase
    end
  end

  assign arready = (rd_state == dbg_rd_rf);  // address held since idle
  assign rvalid  = (rd_state == dbg_resp);
  assign rresp   = resp_okay;

  assign reg_off   = ar_addr - dbg_reg_base;
  assign dbg_raddr = reg_off[6:2];

  always_comb begin
    if (ar_addr == dbg_fwd_cnt) rd_word = fwd_cnt;
    else if (!reg_off[7])       rd_word = dbg_rdata;
    else                        rd_word = '0;  // unmapped
  end

  always_ff @(posedge clk) begin
    if (rd_state == dbg_idle && arvalid) ar_addr <= araddr;
    if (rd_state == dbg_rd_rf)           rdata   <= rd_word;
  end

endmodule

// File: src/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core
  import core_pkg::*, dbg_map_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue_valid_0,
  input  alu_op_t   issue_op_0,
  input  reg_addr_t issue_rd_0,
  input  reg_addr_t issue_rs1_0,
  input  reg_addr_t issue_rs2_0,
  input  logic      issue_use_imm_0,
  input  xdata_t    issue_imm_0,
  input  logic      issue_valid_1,
  input  alu_op_t   issue_op_1,
  input  reg_addr_t issue_rd_1,
  input  reg_addr_t issue_rs1_1,
  input  reg_addr_t issue_rs2_1,
  input  logic      issue_use_imm_1,
  input  xdata_t    issue_imm_1,
  output logic      wb_valid_0,
  output reg_addr_t wb_rd_0,
  output xdata_t    wb_data_0,
  output logic      wb_valid_1,
  output reg_addr_t wb_rd_1,
  output xdata_t    wb_data_1,
  input  axi_addr_t awaddr,
  input  logic      awvalid,
  output logic      awready,
  input  axi_data_t wdata,
  input  logic      wvalid,
  output logic      wready,
  output axi_resp_t bresp,
  output logic      bvalid,
  input  logic      bready,
  input  axi_addr_t araddr,
  input  logic      arvalid,
  output logic      arready,
  output axi_data_t rdata,
  output axi_resp_t rresp,
  output logic      rvalid,
  input  logic      rready
);

  xdata_t    rf_0a, rf_0b, rf_1a, rf_1b;
  xdata_t    src1_0, src2_0, src1_1, src2_1;
  logic      mem_wren_0, mem_wren_1;
  reg_addr_t mem_waddr_0, mem_waddr_1;
  xdata_t    mem_wdata_0, mem_wdata_1;
  fwd_hits_t fwd_hits;
  reg_addr_t dbg_raddr;
  xdata_t    dbg_rdata;
  logic      rden2_0, rden2_1;

  assign rden2_0 = issue_valid_0 & ~issue_use_imm_0;  // rs2 unused with an immediate
  assign rden2_1 = issue_valid_1 & ~issue_use_imm_1;

  reg_file u_rf (
    .clk, .rst_n,
    .we0(wb_valid_0), .waddr0(wb_rd_0), .wdata0(wb_data_0),
    .we1(wb_valid_1), .waddr1(wb_rd_1), .wdata1(wb_data_1),
    .raddr0a(issue_rs1_0), .raddr0b(issue_rs2_0),
    .raddr1a(issue_rs1_1), .raddr1b(issue_rs2_1),
    .dbg_raddr,
    .rdata0a(rf_0a), .rdata0b(rf_0b), .rdata1a(rf_1a), .rdata1b(rf_1b),
    .dbg_rdata
  );

  forwarding u_fwd (
    .rden1_0(issue_valid_0), .rden2_0(rden2_0),
    .raddr1_0(issue_rs1_0), .raddr2_0(issue_rs2_0), .rdata1_0(rf_0a), .rdata2_0(rf_0b),
    .rden1_1(issue_valid_1), .rden2_1(rden2_1),
    .raddr1_1(issue_rs1_1), .raddr2_1(issue_rs2_1), .rdata1_1(rf_1a), .rdata2_1(rf_1b),
    .mem_wren_0, .mem_waddr_0, .mem_wdata_0,
    .wb_wren_0(wb_valid_0), .wb_waddr_0(wb_rd_0), .wb_wdata_0(wb_data_0),
    .mem_wren_1, .mem_waddr_1, .mem_wdata_1,
    .wb_wren_1(wb_valid_1), .wb_waddr_1(wb_rd_1), .wb_wdata_1(wb_data_1),
    .data1_0(src1_0), .data2_0(src2_0), .data1_1(src1_1), .data2_1(src2_1),
    .fwd_hits
  );

  exec_lane u_lane0 (
    .clk, .rst_n,
    .valid(issue_valid_0), .op(issue_op_0), .rd(issue_rd_0),
    .use_imm(issue_use_imm_0), .imm(issue_imm_0), .src1(src1_0), .src2(src2_0),
    .mem_wren(mem_wren_0), .mem_waddr(mem_waddr_0), .mem_wdata(mem_wdata_0),
    .wb_wren(wb_valid_0), .wb_waddr(wb_rd_0), .wb_wdata(wb_data_0)
  );

  exec_lane u_lane1 (
    .clk, .rst_n,
    .valid(issue_valid_1), .op(issue_op_1), .rd(issue_rd_1),
    .use_imm(issue_use_imm_1), .imm(issue_imm_1), .src1(src1_1), .src2(src2_1),
    .mem_wren(mem_wren_1), .mem_waddr(mem_waddr_1), .mem_wdata(mem_wdata_1),
    .wb_wren(wb_valid_1), .wb_waddr(wb_rd_1), .wb_wdata(wb_data_1)
  );

  dbg_regs u_dbg (
    .clk, .rst_n, .fwd_hits, .dbg_raddr, .dbg_rdata,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

endmodule

// File: tests/dual_issue_core_properties.sv
`timescale 1ns/10ps

module dual_issue_core_properties
  import core_pkg::*, dbg_map_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      wb_valid_0,
  input reg_addr_t wb_rd_0,
  input logic      wb_valid_1,
  input reg_addr_t wb_rd_1,
  input logic      rvalid,
  input logic      rready,
  input axi_data_t rdata,
  input logic      bvalid,
  input logic      bready
);

  int fail_count = 0;  // read by the testbench at the end

  wb_rd_nonzero_0: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_0 |-> wb_rd_0 != '0)
    else begin
      fail_count++;
      $error("lane 0 retired to x0");
    end

  wb_rd_nonzero_1: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_1 |-> wb_rd_1 != '0)
    else begin
      fail_count++;
      $error("lane 1 retired to x0");
    end

  rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> $stable(rdata))
    else begin
      fail_count++;
      $error("rdata changed while the read response was stalled");
    end

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  wb_idle_after_reset: assert property (@(posedge clk)
    !rst_n |=> !wb_valid_0 && !wb_valid_1)
    else begin
      fail_count++;
      $error("retirement seen right after reset");
    end

endmodule

bind dual_issue_core dual_issue_core_properties u_props (.*);

// File: tests/tb_dual_issue_core.sv
`timescale 1ns/10ps

module tb_dual_issue_core
  import core_pkg::*, dbg_map_pkg::*;
();

  localparam int n_random    = 400;
  localparam int n_dep       = 200;
  localparam int n_axi_ops   = 72;
  localparam int axi_op_max  = 12;  // worst case per debug access, stall included
  localparam int cycle_limit = 2 * (n_random + n_dep + 8 + n_axi_ops * axi_op_max) + 200;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      issue_valid_0, issue_valid_1;
  alu_op_t   issue_op_0, issue_op_1;
  reg_addr_t issue_rd_0, issue_rd_1;
  reg_addr_t issue_rs1_0, issue_rs1_1;
  reg_addr_t issue_rs2_0, issue_rs2_1;
  logic      issue_use_imm_0, issue_use_imm_1;
  xdata_t    issue_imm_0, issue_imm_1;
  logic      wb_valid_0, wb_valid_1;
  reg_addr_t wb_rd_0, wb_rd_1;
  xdata_t    wb_data_0, wb_data_1;
  axi_addr_t awaddr;
  logic      awvalid, awready;
  axi_data_t wdata;
  logic      wvalid, wready;
  axi_resp_t bresp;
  logic      bvalid, bready;
  axi_addr_t araddr;
  logic      arvalid, arready;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rvalid, rready;

  int        seed = 44086;
  int        cycles = 0;
  int        check_count = 0;
  int        err_count = 0;
  int        test_err_base = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  string     cur_test;

  // pair being issued
  logic      v [2];
  alu_op_t   op [2];
  reg_addr_t rd [2];
  reg_addr_t rs1 [2];
  reg_addr_t rs2 [2];
  logic      ui [2];
  xdata_t    imm [2];

  // reference state
  xdata_t      model_rf [32];
  fwd_cnt_t    model_hits;
  reg_addr_t   dst_m [2];     // destinations of the previous pair, 0 when none
  reg_addr_t   dst_w [2];     // and of the pair before it
  logic [37:0] exp_q0 [$];    // {valid, rd, data}
  logic [37:0] exp_q1 [$];

  dual_issue_core DUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", cur_test, err_count - test_err_base);
    end
  endtask

  function automatic xdata_t alu_ref(input alu_op_t f, input xdata_t a, input xdata_t b);
    case (f)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  function automatic logic in_flight(input reg_addr_t a);
    return a != '0 && (a == dst_m[0] || a == dst_m[1] || a == dst_w[0] || a == dst_w[1]);
  endfunction

  // dependent mode prefers recent destinations
  function automatic reg_addr_t pick_src(input logic dependent);
    logic [31:0] r;
    reg_addr_t   a;
    r = $random(seed);
    a = r[8:4];
    if (dependent && r[1:0] != 2'b00) begin
      a = r[3] ? dst_m[r[2]] : dst_w[r[2]];
      if (a == '0) a = {2'b00, r[10:8]};
    end
    return a;
  endfunction

  task automatic draw_pair(input logic dependent);
    logic [31:0] r;
    for (int l = 0; l < 2; l++) begin
      r      = $random(seed);
      v[l]   = r[2:0] != 3'd0;
      op[l]  = alu_op_t'(r[5:3]);
      ui[l]  = r[6];
      rd[l]  = dependent ? {2'b00, r[9:7]} : r[11:7];  // narrow range forces reuse
      rs1[l] = pick_src(dependent);
      rs2[l] = pick_src(dependent);
      imm[l] = $random(seed);
    end
    if (dependent && r[12]) rd[1] = rd[0];
    // no reads of lane 0's result inside the pair
    if (v[0] && rd[0] != '0) begin
      while (rs1[1] == rd[0]) rs1[1] = pick_src(dependent);
      while (rs2[1] == rd[0]) rs2[1] = pick_src(dependent);
    end
  endtask

  // in order, lane 0 then lane 1
  task automatic apply_model();
    xdata_t    opa;
    xdata_t    opb;
    xdata_t    res;
    reg_addr_t dst [2];
    logic      wr;
    for (int l = 0; l < 2; l++) begin
      if (v[l] && in_flight(rs1[l])) model_hits++;
      if (v[l] && !ui[l] && in_flight(rs2[l])) model_hits++;
      opa    = model_rf[rs1[l]];
      opb    = ui[l] ? imm[l] : model_rf[rs2[l]];
      res    = alu_ref(op[l], opa, opb);
      wr     = v[l] && rd[l] != '0;
      dst[l] = wr ? rd[l] : '0;
      if (wr) model_rf[rd[l]] = res;
      if (l == 0) exp_q0.push_back({wr, rd[l], res});
      else        exp_q1.push_back({wr, rd[l], res});
    end
    dst_w = dst_m;
    dst_m = dst;
  endtask

  task automatic check_lane(input string lane, input logic [37:0] e, input logic valid,
                            input reg_addr_t rd_out, input xdata_t data);
    compare_values({cur_test, " wb_valid_", lane}, 32'(e[37]), 32'(valid));
    if (e[37]) begin
      compare_values({cur_test, " wb_rd_", lane}, 32'(e[36:32]), 32'(rd_out));
      compare_values({cur_test, " wb_data_", lane}, e[31:0], data);
    end
  endtask

  // called on a falling edge; outputs show the pair from two calls back
  task automatic issue_cycle();
    logic [37:0] e0;
    logic [37:0] e1;
    e0 = exp_q0.pop_front();
    e1 = exp_q1.pop_front();
    check_lane("0", e0, wb_valid_0, wb_rd_0, wb_data_0);
    check_lane("1", e1, wb_valid_1, wb_rd_1, wb_data_1);
    apply_model();
    issue_valid_0   = v[0];
    issue_op_0      = op[0];
    issue_rd_0      = rd[0];
    issue_rs1_0     = rs1[0];
    issue_rs2_0     = rs2[0];
    issue_use_imm_0 = ui[0];
    issue_imm_0     = imm[0];
    issue_valid_1   = v[1];
    issue_op_1      = op[1];
    issue_rd_1      = rd[1];
    issue_rs1_1     = rs1[1];
    issue_rs2_1     = rs2[1];
    issue_use_imm_1 = ui[1];
    issue_imm_1     = imm[1];
    @(negedge clk);
  endtask

  task automatic drain_pipe();
    v[0] = 1'b0;
    v[1] = 1'b0;
    repeat (2) issue_cycle();
  endtask

  task automatic dbg_read(input axi_addr_t addr, input int hold, output axi_data_t data,
                          output axi_resp_t resp);
    axi_data_t first;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(negedge clk);  // address taken at the edge just passed
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    first = rdata;
    if (hold > 0) begin
      repeat (hold) @(negedge clk);
      compare_values({cur_test, " rvalid held"}, 32'd1, 32'(rvalid));
      compare_values({cur_test, " rdata held"}, first, rdata);
      rready = 1'b1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic dbg_write(input axi_addr_t addr, input axi_data_t data, input int hold);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    if (hold > 0) begin
      repeat (hold) @(negedge clk);
      compare_values({cur_test, " bvalid held"}, 32'd1, 32'(bvalid));
      bready = 1'b1;
    end
    compare_values({cur_test, " bresp"}, 32'(resp_okay), 32'(bresp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_all_regs();
    axi_data_t d;
    axi_resp_t r;
    for (int i = 0; i < 32; i++) begin
      dbg_read(axi_addr_t'(i * 4), 0, d, r);
      compare_values($sformatf("%s x%0d", cur_test, i), model_rf[i], d);
      compare_values({cur_test, " rresp"}, 32'(resp_okay), 32'(r));
    end
  endtask

  initial begin
    axi_data_t d;
    axi_resp_t r;
    rst_n = 1'b0;
    issue_valid_0 = 1'b0;
    issue_op_0 = alu_add;
    issue_rd_0 = '0;
    issue_rs1_0 = '0;
    issue_rs2_0 = '0;
    issue_use_imm_0 = 1'b0;
    issue_imm_0 = '0;
    issue_valid_1 = 1'b0;
    issue_op_1 = alu_add;
    issue_rd_1 = '0;
    issue_rs1_1 = '0;
    issue_rs2_1 = '0;
    issue_use_imm_1 = 1'b0;
    issue_imm_1 = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    model_hits = '0;
    dst_m = '{default: '0};
    dst_w = '{default: '0};
    repeat (2) begin
      exp_q0.push_back('0);
      exp_q1.push_back('0);
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset");
    compare_values({cur_test, " wb_valid_0"}, 32'd0, 32'(wb_valid_0));
    compare_values({cur_test, " wb_valid_1"}, 32'd0, 32'(wb_valid_1));
    read_all_regs();
    dbg_read(dbg_fwd_cnt, 0, d, r);
    compare_values({cur_test, " fwd count"}, 32'd0, d);
    end_test();

    begin_test("random");
    repeat (n_random) begin
      draw_pair(1'b0);
      issue_cycle();
    end
    drain_pipe();
    end_test();

    begin_test("dependent");
    repeat (n_dep) begin
      draw_pair(1'b1);
      issue_cycle();
    end
    drain_pipe();
    end_test();

    begin_test("readback");
    read_all_regs();
    end_test();

    begin_test("fwd_count");
    dbg_read(dbg_fwd_cnt, 0, d, r);
    compare_values({cur_test, " before clear"}, model_hits, d);
    dbg_write(dbg_fwd_cnt, $random(seed), 3);  // bready held low for a few cycles
    model_hits = '0;
    dbg_read(dbg_fwd_cnt, 0, d, r);
    compare_values({cur_test, " after clear"}, model_hits, d);
    end_test();

    begin_test("axi_stall");
    dbg_read(8'h14, 6, d, r);  // x5 with rready held low
    compare_values({cur_test, " x5"}, model_rf[5], d);
    compare_values({cur_test, " rresp"}, 32'(resp_okay), 32'(r));
    dbg_read(8'hc0, 0, d, r);
    compare_values({cur_test, " unmapped data"}, 32'd0, d);
    compare_values({cur_test, " unmapped rresp"}, 32'(resp_okay), 32'(r));
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, check_count, err_count, DUT.u_props.fail_count);
    if (err_count == 0 && DUT.u_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dual_issue_core.f
src/core_pkg.sv
src/dbg_map_pkg.sv
src/reg_file.sv
src/forwarding.sv
src/exec_lane.sv
src/dbg_regs.sv
src/dual_issue_core.sv
tests/dual_issue_core_properties.sv
tests/tb_dual_issue_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert -j 0 --top-module tb_dual_issue_core \
  -f dual_issue_core.f -o tb_dual_issue_core > "$log" 2>&1 \
  && ./obj_dir/tb_dual_issue_core +verilator+error+limit+100 >> "$log" 2>&1 \
  || echo "build or simulation stopped with an error" >> "$log"
cat "$log"
grep -q "RESULT: FAIL" "$log" && exit 1
grep -q "RESULT: PASS" "$log" || exit 1
exit 0
